// File: Makefile
# Verilator simulation of the game port testbench.

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module game_port_tb -Mdir obj_dir -o game_port_tb

run: compile
	./obj_dir/game_port_tb | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: all.f
verilog/game_port_pkg.sv
verilog/pad_input_sync.sv
verilog/axis_oneshot.sv
verilog/game_port.sv
verilog/game_port_top.sv
dv/game_port_tb.sv

// File: dv/game_port_stimulus.txt
# One command per line. Hex arguments except T and I, which are decimal.
# P pad0 pad1 | W addr | R addr expected | B axis_bits | T axis load_count | I cycles
R 1 f0
B 0
B 0
B 0
R 0 ff
R 3 ff
R 7 ff
# All directions released.
P 00 00
W 1
R 1 ff
T 0 200
T 1 200
T 2 200
T 3 200
R 1 f0
# Pad 0 left and down, pad 1 right with Y released.
P 06 01
W 1
R 1 ff
T 0 8
T 1 397
T 2 397
T 3 200
# Restart during discharge, left beats right and up beats down.
P 00 00
W 1
I 20000
P 03 0c
W 1
T 0 8
T 3 8
T 1 200
T 2 200
# Other offsets start nothing.
P 00 00
W 2
W 0
W 7
R 1 f0
# Pressed buttons read as zero.
P 30 10
R 1 80

// File: dv/game_port_tb.sv
module game_port_tb;

	import game_port_pkg::*;

	// Bench constants.
	localparam int unsigned seed           = 32'heace_57c5;
	localparam int          timeout_cycles = 120000;
	localparam int          clock_half     = 4;
	localparam string       stim_file      = "dv/game_port_stimulus.txt";

	// DUT ports.
	logic                 CLOCK;
	logic                 RESET_N;
	logic [2:0]           io_addr;
	logic                 io_read;
	logic                 io_write;
	logic [7:0]           io_data_out;
	logic [pad_width-1:0] pad_0;
	logic [pad_width-1:0] pad_1;

	// Error count and axis timing marks.
	int errors;
	int cycle;
	int write_cycle;
	int fall_cycle [4];

	game_port_top dut_i (
		.CLOCK       (CLOCK),
		.RESET_N     (RESET_N),
		.io_addr     (io_addr),
		.io_read     (io_read),
		.io_write    (io_write),
		.io_data_out (io_data_out),
		.pad_0       (pad_0),
		.pad_1       (pad_1)
	);

	// Period of 8.
	always #clock_half CLOCK = ~CLOCK;

	// Counts rising edges.
	always @(posedge CLOCK) begin
		cycle <= cycle + 1;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// Bus idle for a number of cycles.
	task automatic bus_idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge CLOCK);
			io_read  <= 1'b0;
			io_write <= 1'b0;
		end
	endtask

	// Short random pause between commands.
	task automatic idle_gap();
		bus_idle(int'($urandom_range(3, 0)));
	endtask

	// One-cycle strobe.
	// The timers load on the edge that drops it.
	task automatic bus_write(input logic [2:0] addr);
		@(posedge CLOCK);
		io_read  <= 1'b0;
		io_write <= 1'b1;
		io_addr  <= addr;
		@(posedge CLOCK);
		io_write <= 1'b0;
		@(negedge CLOCK);
		if (addr == 3'd1) begin
			write_cycle = cycle;
			for (int i = 0; i < 4; i++) begin
				fall_cycle[i] = -1;
			end
		end
	endtask

	// Read strobe stays up until the next command drives the bus.
	task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
		@(posedge CLOCK);
		io_read  <= 1'b1;
		io_write <= 1'b0;
		io_addr  <= addr;
		@(negedge CLOCK);
		data = io_data_out;
	endtask

	// Reads every cycle and marks each axis where it first reads low.
	task automatic wait_axis_fall(input int axis);
		logic [7:0] data;
		int         waited;
		waited = 0;
		while (fall_cycle[axis] < 0 && waited < timeout_cycles) begin
			bus_read(3'd1, data);
			waited++;
			for (int i = 0; i < 4; i++) begin
				if (fall_cycle[i] < 0 && !data[i]) begin
					fall_cycle[i] = cycle;
				end
			end
		end
		if (fall_cycle[axis] < 0) begin
			errors++;
			$display("Axis %0d did not drop within %0d cycles", axis, timeout_cycles);
		end
	endtask

	// Window is (N-1)*256+1 to N*256+1 cycles from the write.
	task automatic check_axis(input int axis, input int load_count);
		int duration;
		int low;
		int high;
		int nearest;
		wait_axis_fall(axis);
		if (fall_cycle[axis] >= 0) begin
			duration = fall_cycle[axis] - write_cycle;
			low      = (load_count - 1) * (1 << div_width) + 1;
			high     = load_count * (1 << div_width) + 1;
			nearest  = (duration < low) ? low : ((duration > high) ? high : duration);
			check_value($sformatf("axis_%0d_duration", axis), duration, nearest);
		end
	endtask

	initial begin
		int               fd;
		int               code;
		logic [7:0]       cmd;
		logic [31:0]      arg_a;
		logic [31:0]      arg_b;
		logic [7:0]       data;
		logic [3:0]       buttons;
		logic [8*128-1:0] line;

		CLOCK       = 1'b0;
		RESET_N     = 1'b0;
		io_addr     = 3'd0;
		io_read     = 1'b0;
		io_write    = 1'b0;
		pad_0       = '0;
		pad_1       = '0;
		errors      = 0;
		cycle       = 0;
		write_cycle = 0;
		for (int i = 0; i < 4; i++) begin
			fall_cycle[i] = -1;
		end
		void'($urandom(seed));

		repeat (5) @(posedge CLOCK);
		RESET_N <= 1'b1;

		fd = $fopen(stim_file, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file %s", stim_file);
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %c", cmd);
				if (code != 1) begin
					break;
				end
				case (cmd)
					"#": code = $fgets(line, fd);
					// Directions and buttons come from the file and spare bits are random.
					"P": begin
						code = $fscanf(fd, "%h %h", arg_a, arg_b);
						idle_gap();
						@(posedge CLOCK);
						pad_0 <= {6'($urandom), arg_a[5:0]};
						pad_1 <= {6'($urandom), arg_b[5:0]};
						io_read <= 1'b0;
						bus_idle(3);
					end
					"W": begin
						code = $fscanf(fd, "%h", arg_a);
						idle_gap();
						bus_write(arg_a[2:0]);
					end
					"R": begin
						code = $fscanf(fd, "%h %h", arg_a, arg_b);
						idle_gap();
						bus_read(arg_a[2:0], data);
						check_value("io_data_out", 32'(data), 32'(arg_b[7:0]));
					end
					// Random buttons read back inverted above the axis bits.
					"B": begin
						code = $fscanf(fd, "%h", arg_a);
						idle_gap();
						buttons = 4'($urandom);
						@(posedge CLOCK);
						pad_0[5:4] <= buttons[1:0];
						pad_1[5:4] <= buttons[3:2];
						io_read <= 1'b0;
						bus_idle(3);
						bus_read(3'd1, data);
						check_value("io_data_out", 32'(data), 32'({~buttons[3], ~buttons[2],
							~buttons[1], ~buttons[0], arg_a[3:0]}));
					end
					// Polling starts right away so every cycle is sampled.
					"T": begin
						code = $fscanf(fd, "%d %d", arg_a, arg_b);
						check_axis(int'(arg_a), int'(arg_b));
					end
					"I": begin
						code = $fscanf(fd, "%d", arg_a);
						bus_idle(int'(arg_a));
					end
					default: begin
						errors++;
						$display("Unknown command %c in the stimulus file", cmd);
						break;
					end
				endcase
			end
			$fclose(fd);
		end

		bus_idle(2);
		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: verilog/axis_oneshot.sv
module axis_oneshot (
	input  logic                                 CLOCK,
	input  logic                                 RESET_N,
	input  logic                                 load,
	input  logic [game_port_pkg::axis_width-1:0] load_count,
	input  logic                                 tick,
	output logic                                 active
);

	import game_port_pkg::*;

	// Timer state and remaining charge.
	axis_state_e           state;
	logic [axis_width-1:0] count;

	// Idle waits for a load.
	// Discharging counts down on ticks.
	// A new load restarts it.
	always_ff @(posedge CLOCK or negedge RESET_N) begin
		if (!RESET_N) begin
			state <= axis_idle;
			count <= '0;
		end else begin
			case (state)
				axis_idle: begin
					if (load) begin
						state <= axis_discharge;
						count <= load_count;
					end
				end
				axis_discharge: begin
					if (load) begin
						count <= load_count;
					end else if (tick) begin
						// Last tick empties the counter.
						if (count > axis_width'(1)) begin
							count <= count - 1'b1;
						end else begin
							count <= '0;
							state <= axis_idle;
						end
					end
				end
				default: begin
					state <= axis_idle;
				end
			endcase
		end
	end

	// Axis bit is high for the whole discharge.
	assign active = (state == axis_discharge);

	// While the axis is active the counter still holds charge.
	assert property (@(posedge CLOCK) disable iff (!RESET_N)
		active == (count != '0));

	// Counter never holds more than the longest position.
	assert property (@(posedge CLOCK) disable iff (!RESET_N)
		count <= axis_max);

endmodule

// File: verilog/game_port.sv
module game_port (
	input  logic                                CLOCK,
	input  logic                                RESET_N,
	input  logic [2:0]                          io_addr,
	input  logic                                io_read,
	input  logic                                io_write,
	output logic [7:0]                          io_data_out,
	input  logic [game_port_pkg::pad_width-1:0] pad_0_sync,
	input  logic [game_port_pkg::pad_width-1:0] pad_1_sync
);

	import game_port_pkg::*;

	// Axis index order.
	// 0 pad 0 X, 1 pad 0 Y, 2 pad 1 X, 3 pad 1 Y.
	localparam int num_axes = 4;

	// Free-running tick divider.
	logic [div_width-1:0]  div_count;
	logic                  tick;

	// Register decode.
	logic                  game_sel;
	logic                  axis_load;

	// Per-axis load counts and timer outputs.
	logic [axis_width-1:0] axis_load_count [num_axes];
	logic [num_axes-1:0]   axis_active;

	// Status byte as read from the game register.
	logic [7:0]            status;

	// Direction pair to load count.
	// Left or up beats right or down.
	function automatic logic [axis_width-1:0] axis_count(input logic neg, input logic pos);
		logic [axis_width-1:0] result;
		if (neg) begin
			result = axis_min;
		end else if (pos) begin
			result = axis_max;
		end else begin
			result = axis_mid;
		end
		return result;
	endfunction

	// Divider wraps every 256 clocks.
	always_ff @(posedge CLOCK or negedge RESET_N) begin
		if (!RESET_N) begin
			div_count <= '0;
		end else begin
			div_count <= div_count + 1'b1;
		end
	end

	// One tick per wrap.
	assign tick = (div_count == '0);

	// Game register hit.
	assign game_sel  = (port_reg_e'(io_addr) == reg_game);
	// The strobe alone fires the timers since the write data plays no part.
	assign axis_load = io_write && game_sel;

	// X uses left and right, Y uses up and down.
	assign axis_load_count[0] = axis_count(pad_0_sync[pad_left], pad_0_sync[pad_right]);
	assign axis_load_count[1] = axis_count(pad_0_sync[pad_up], pad_0_sync[pad_down]);
	assign axis_load_count[2] = axis_count(pad_1_sync[pad_left], pad_1_sync[pad_right]);
	assign axis_load_count[3] = axis_count(pad_1_sync[pad_up], pad_1_sync[pad_down]);

	// Four identical axis timers.
	for (genvar i = 0; i < num_axes; i++) begin : g_axis
		axis_oneshot axis_i (
			.CLOCK      (CLOCK),
			.RESET_N    (RESET_N),
			.load       (axis_load),
			.load_count (axis_load_count[i]),
			.tick       (tick),
			.active     (axis_active[i])
		);
	end

	// Buttons read as 0 when pressed.
	// Axis bits read as 1 while the timer runs.
	assign status = {
		~pad_1_sync[pad_but2],
		~pad_1_sync[pad_but1],
		~pad_0_sync[pad_but2],
		~pad_0_sync[pad_but1],
		axis_active[3],
		axis_active[2],
		axis_active[1],
		axis_active[0]
	};

	// Reads are side-effect free.
	// Anything but a game register read floats high.
	assign io_data_out = (io_read && game_sel) ? status : 8'hff;

	// Host never reads and writes in the same cycle.
	assert property (@(posedge CLOCK) disable iff (!RESET_N)
		!(io_read && io_write));

endmodule

// File: verilog/game_port_pkg.sv
package game_port_pkg;

	// Tick divider width.
	// One tick every 256 clocks.
	localparam int div_width = 8;

	// Axis down-counter width.
	localparam int axis_width = 9;

	// Load counts standing for the stick resistance.
	// Minimum is left or up.
	localparam logic [axis_width-1:0] axis_min = 9'd8;
	// Centre, for a released direction.
	localparam logic [axis_width-1:0] axis_mid = 9'd200;
	// Maximum is right or down.
	localparam logic [axis_width-1:0] axis_max = 9'd397;

	// Joypad word width.
	// Bits 0 to 3 are right, left, down, up.
	// Bits 4 and 5 are button 1 and button 2.
	localparam int pad_width = 12;

	// Bit positions inside a joypad word.
	localparam int pad_right = 0;
	localparam int pad_left  = 1;
	localparam int pad_down  = 2;
	localparam int pad_up    = 3;
	localparam int pad_but1  = 4;
	localparam int pad_but2  = 5;

	// Register offsets on the I/O bus.
	// Only the game register exists, other offsets read as all ones.
	typedef enum logic [2:0] {
		reg_game = 3'd1
	} port_reg_e;

	// Axis timer states.
	typedef enum logic {
		axis_idle      = 1'b0,
		axis_discharge = 1'b1
	} axis_state_e;

endpackage

// File: verilog/game_port_top.sv
module game_port_top (
	input  logic                                CLOCK,
	input  logic                                RESET_N,
	input  logic [2:0]                          io_addr,
	input  logic                                io_read,
	input  logic                                io_write,
	output logic [7:0]                          io_data_out,
	input  logic [game_port_pkg::pad_width-1:0] pad_0,
	input  logic [game_port_pkg::pad_width-1:0] pad_1
);

	// Pad words after the synchronizer.
	logic [game_port_pkg::pad_width-1:0] pad_0_sync;
	logic [game_port_pkg::pad_width-1:0] pad_1_sync;

	// Bring the pads into the CLOCK domain.
	pad_input_sync pad_sync_i (
		.CLOCK      (CLOCK),
		.RESET_N    (RESET_N),
		.pad_0      (pad_0),
		.pad_1      (pad_1),
		.pad_0_sync (pad_0_sync),
		.pad_1_sync (pad_1_sync)
	);

	// Register, divider and axis timers.
	// Bus signals pass straight through.
	game_port game_port_i (
		.CLOCK       (CLOCK),
		.RESET_N     (RESET_N),
		.io_addr     (io_addr),
		.io_read     (io_read),
		.io_write    (io_write),
		.io_data_out (io_data_out),
		.pad_0_sync  (pad_0_sync),
		.pad_1_sync  (pad_1_sync)
	);

endmodule

// File: verilog/pad_input_sync.sv
module pad_input_sync (
	input  logic                              CLOCK,
	input  logic                              RESET_N,
	input  logic [game_port_pkg::pad_width-1:0] pad_0,
	input  logic [game_port_pkg::pad_width-1:0] pad_1,
	output logic [game_port_pkg::pad_width-1:0] pad_0_sync,
	output logic [game_port_pkg::pad_width-1:0] pad_1_sync
);

	import game_port_pkg::*;

	// First stage that may go metastable.
	logic [pad_width-1:0] pad_0_meta;
	logic [pad_width-1:0] pad_1_meta;

	// Pads come from the host clock domain.
	// Two flops per bit before the game port logic sees them.
	always_ff @(posedge CLOCK or negedge RESET_N) begin
		if (!RESET_N) begin
			pad_0_meta <= '0;
			pad_1_meta <= '0;
		end else begin
			pad_0_meta <= pad_0;
			pad_1_meta <= pad_1;
		end
	end

	// Second stage holds the settled values.
	// A pad change shows here two cycles later.
	always_ff @(posedge CLOCK or negedge RESET_N) begin
		if (!RESET_N) begin
			pad_0_sync <= '0;
			pad_1_sync <= '0;
		end else begin
			pad_0_sync <= pad_0_meta;
			pad_1_sync <= pad_1_meta;
		end
	end

endmodule
